/* src/mipsPkg.sv */
package mipsPkg;

    localparam int DataWidth    = 32;  // Machine word
    localparam int RegAddrWidth = 5;   // Register index
    localparam int NumRegs      = 32;
    localparam int ImemWords    = 256; // Instruction store depth
    localparam int DmemWords    = 256; // Data store depth

    // Opcodes
    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpAddi  = 6'h08;
    localparam logic [5:0] OpLw    = 6'h23;
    localparam logic [5:0] OpSw    = 6'h2B;
    localparam logic [5:0] OpBeq   = 6'h04;
    localparam logic [5:0] OpBne   = 6'h05;
    localparam logic [5:0] OpJ     = 6'h02;

    // Funct codes for R-type
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr  = 6'h25;
    localparam logic [5:0] FnSlt = 6'h2A;

    // ALU ops whose top bit inverts b
    localparam logic [2:0] AluAnd = 3'b000;
    localparam logic [2:0] AluOr  = 3'b001;
    localparam logic [2:0] AluAdd = 3'b010;
    localparam logic [2:0] AluSub = 3'b110;
    localparam logic [2:0] AluSlt = 3'b111;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [RegAddrWidth-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } rFields_t;

    typedef struct packed {
        logic [5:0]              opcode;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [15:0]             imm;
    } iFields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target; // Word target within the 256 MB region
    } jFields_t;

    // One fetched word seen three ways
    typedef union packed {
        rFields_t r;
        iFields_t i;
        jFields_t j;
    } instrWord_t;

    typedef struct packed {
        logic       regDst;   // Write rd instead of rt
        logic       aluSrc;   // Immediate as operand b
        logic       memWrite;
        logic       memToReg; // Write back load data
        logic       regWrite;
        logic       beq;
        logic       bne;
        logic       jump;
        logic [2:0] aluOp;
    } ctrlBundle_t;

    typedef struct packed {
        logic                 en;
        logic [DataWidth-1:0] addr; // Word-aligned byte address
        logic [DataWidth-1:0] data;
    } storeBus_t;

    typedef struct packed {
        logic                         en;
        logic [$clog2(ImemWords)-1:0] idx; // Word index
        logic [DataWidth-1:0]         data;
    } imemLoad_t;

endpackage

/* src/instructionMemory.sv */
`timescale 1ns/10ps

module instructionMemory (
    input  logic                           Clk,
    input  mipsPkg::imemLoad_t             load,
    input  logic [mipsPkg::DataWidth-1:0]  pc,
    output mipsPkg::instrWord_t            instr
);

    logic [mipsPkg::DataWidth-1:0] mem [mipsPkg::ImemWords]; // Program store fed by the load port

    always_ff @(posedge Clk) begin
        if (load.en) begin
            mem[load.idx] <= load.data; // One word per strobe
        end
    end

    assign instr = mem[pc[$clog2(mipsPkg::ImemWords)+1:2]]; // Byte pc to word index

    // Loads come only while the core is parked at word 0 by reset
    imemLoadInResetA: assert property (@(posedge Clk) load.en |-> pc == '0)
        else $error("instruction load while core is running, pc=%h", pc);

    // Next-pc logic never produces a misaligned fetch
    pcAlignedA: assert property (@(posedge Clk) !$isunknown(pc) |-> pc[1:0] == 2'b00)
        else $error("misaligned fetch at pc=%h", pc);

endmodule

/* src/controlDecoder.sv */
`timescale 1ns/10ps

module controlDecoder (
    input  mipsPkg::instrWord_t  instr,
    output mipsPkg::ctrlBundle_t ctrl
);

    always_comb begin
        ctrl = '0; // Everything inactive by default
        case (instr.r.opcode)
            mipsPkg::OpRType: begin
                ctrl.regDst   = 1'b1; // Result goes to rd
                ctrl.regWrite = 1'b1;
                case (instr.r.funct)
                    mipsPkg::FnAdd: ctrl.aluOp = mipsPkg::AluAdd;
                    mipsPkg::FnSub: ctrl.aluOp = mipsPkg::AluSub;
                    mipsPkg::FnAnd: ctrl.aluOp = mipsPkg::AluAnd;
                    mipsPkg::FnOr:  ctrl.aluOp = mipsPkg::AluOr;
                    mipsPkg::FnSlt: ctrl.aluOp = mipsPkg::AluSlt;
                    default:        ctrl = '0; // Unknown funct acts as nop
                endcase
            end
            mipsPkg::OpAddi: begin
                ctrl.aluSrc   = 1'b1; // rs + imm
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::AluAdd;
            end
            mipsPkg::OpLw: begin
                ctrl.aluSrc   = 1'b1; // Address = rs + imm
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::AluAdd;
            end
            mipsPkg::OpSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1; // rt goes out on the store bus
                ctrl.aluOp    = mipsPkg::AluAdd;
            end
            mipsPkg::OpBeq: begin
                ctrl.beq   = 1'b1;
                ctrl.aluOp = mipsPkg::AluSub; // Compare via zero flag
            end
            mipsPkg::OpBne: begin
                ctrl.bne   = 1'b1;
                ctrl.aluOp = mipsPkg::AluSub;
            end
            mipsPkg::OpJ: begin
                ctrl.jump = 1'b1; // ALU result ignored
            end
            default: begin
                ctrl = '0; // Undefined opcode still advances pc
            end
        endcase
    end

endmodule

/* src/claAlu.sv */
`timescale 1ns/10ps

module claAlu (
    input  logic [mipsPkg::DataWidth-1:0] a,
    input  logic [mipsPkg::DataWidth-1:0] b,
    input  logic [2:0]                    aluOp,
    output logic [mipsPkg::DataWidth-1:0] result,
    output logic                          zero
);

    logic [mipsPkg::DataWidth-1:0]   bEff;     // b or ~b
    logic [mipsPkg::DataWidth-1:0]   gen;      // Per-bit generate
    logic [mipsPkg::DataWidth-1:0]   prop;     // Per-bit propagate
    logic [mipsPkg::DataWidth-1:0]   carry;    // Carry into each bit
    logic [mipsPkg::DataWidth-1:0]   sum;
    logic [mipsPkg::DataWidth/4-1:0] grpGen;   // Group generate
    logic [mipsPkg::DataWidth/4-1:0] grpProp;  // Group propagate
    logic [mipsPkg::DataWidth/4-1:0] grpCarry; // Carry into each group
    logic                            cin;

    // Sum-of-products carry after n positions at either level
    function automatic logic lookahead(
        input logic [mipsPkg::DataWidth/4-1:0] g,
        input logic [mipsPkg::DataWidth/4-1:0] p,
        input logic                            c0,
        input int                              n
    );
        logic c;
        logic chain;
        c = c0;
        for (int m = 0; m < n; m++) begin
            c &= p[m]; // Carry-in passes all positions
        end
        for (int j = 0; j < n; j++) begin
            chain = g[j]; // Generated at j, propagated above
            for (int m = j + 1; m < n; m++) begin
                chain &= p[m];
            end
            c |= chain;
        end
        return c;
    endfunction

    assign cin  = aluOp[2]; // +1 completes two's complement on sub
    assign bEff = aluOp[2] ? ~b : b;
    assign gen  = a & bEff;
    assign prop = a ^ bEff;

    // Group G/P from 4-bit slices
    always_comb begin
        for (int k = 0; k < mipsPkg::DataWidth / 4; k++) begin
            grpGen[k]  = lookahead({{(mipsPkg::DataWidth/4-4){1'b0}}, gen[4*k +: 4]},
                                   {{(mipsPkg::DataWidth/4-4){1'b0}}, prop[4*k +: 4]},
                                   1'b0, 4);
            grpProp[k] = &prop[4*k +: 4];
        end
    end

    // Block lookahead across groups
    always_comb begin
        for (int k = 0; k < mipsPkg::DataWidth / 4; k++) begin
            grpCarry[k] = lookahead(grpGen, grpProp, cin, k);
        end
    end

    // Bit carries inside each group
    always_comb begin
        for (int k = 0; k < mipsPkg::DataWidth / 4; k++) begin
            for (int i = 0; i < 4; i++) begin
                carry[4*k+i] = lookahead({{(mipsPkg::DataWidth/4-4){1'b0}}, gen[4*k +: 4]},
                                         {{(mipsPkg::DataWidth/4-4){1'b0}}, prop[4*k +: 4]},
                                         grpCarry[k], i);
            end
        end
    end

    assign sum = prop ^ carry;

    always_comb begin
        case (aluOp)
            mipsPkg::AluAnd: result = a & bEff;
            mipsPkg::AluOr:  result = a | bEff;
            mipsPkg::AluAdd,
            mipsPkg::AluSub: result = sum;
            mipsPkg::AluSlt: result = {{(mipsPkg::DataWidth-1){1'b0}}, sum[mipsPkg::DataWidth-1]};
            default:         result = '0;
        endcase
    end

    assign zero = (result == '0); // Drives beq/bne

endmodule

/* src/registerFile.sv */
`timescale 1ns/10ps

module registerFile (
    input  logic                             Clk,
    input  logic                             rst,
    input  logic [mipsPkg::RegAddrWidth-1:0] rs,
    input  logic [mipsPkg::RegAddrWidth-1:0] rt,
    input  logic [mipsPkg::RegAddrWidth-1:0] wrIdx,
    input  logic [mipsPkg::DataWidth-1:0]    wrData,
    input  logic                             wrEn,
    output logic [mipsPkg::DataWidth-1:0]    rsData,
    output logic [mipsPkg::DataWidth-1:0]    rtData
);

    logic [mipsPkg::DataWidth-1:0] regs [mipsPkg::NumRegs];

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < mipsPkg::NumRegs; i++) begin
                regs[i] <= '0; // Whole file cleared
            end
        end else if (wrEn && wrIdx != '0) begin
            regs[wrIdx] <= wrData; // $zero stays zero
        end
    end

    assign rsData = regs[rs]; // Async reads
    assign rtData = regs[rt];

    // $zero reads zero on both ports whatever the core writes
    zeroRegRsA: assert property (@(posedge Clk) disable iff (rst)
        rs == '0 |-> rsData == '0)
        else $error("register 0 nonzero on rs port");

    zeroRegRtA: assert property (@(posedge Clk) disable iff (rst)
        rt == '0 |-> rtData == '0)
        else $error("register 0 nonzero on rt port");

endmodule

/* src/dataMemory.sv */
`timescale 1ns/10ps

module dataMemory (
    input  logic                          Clk,
    input  logic [mipsPkg::DataWidth-1:0] rdAddr,
    output logic [mipsPkg::DataWidth-1:0] rdData,
    input  mipsPkg::storeBus_t            store
);

    logic [mipsPkg::DataWidth-1:0] mem [mipsPkg::DmemWords];
    logic [$clog2(mipsPkg::DmemWords)-1:0] rdIdx; // Byte address / 4
    logic [$clog2(mipsPkg::DmemWords)-1:0] wrIdx;

    assign rdIdx = rdAddr[$clog2(mipsPkg::DmemWords)+1:2];
    assign wrIdx = store.addr[$clog2(mipsPkg::DmemWords)+1:2];

    assign rdData = mem[rdIdx]; // Combinational lw path

    always_ff @(posedge Clk) begin
        if (store.en) begin
            mem[wrIdx] <= store.data; // Lands at end of the sw cycle
        end
    end

    // ALU-computed store address must be word aligned
    storeAlignedA: assert property (@(posedge Clk)
        store.en |-> store.addr[1:0] == 2'b00)
        else $error("misaligned store to %h", store.addr);

endmodule

/* src/datapath.sv */
`timescale 1ns/10ps

module datapath (
    input  logic                          Clk,
    input  logic                          rst,
    input  mipsPkg::instrWord_t           instr,
    input  mipsPkg::ctrlBundle_t          ctrl,
    input  logic [mipsPkg::DataWidth-1:0] memRdData,
    output logic [mipsPkg::DataWidth-1:0] pc,
    output logic [mipsPkg::DataWidth-1:0] memRdAddr,
    output mipsPkg::storeBus_t            store
);

    logic [mipsPkg::DataWidth-1:0]    pcPlus4;
    logic [mipsPkg::DataWidth-1:0]    pcNext;
    logic [mipsPkg::DataWidth-1:0]    branchTarget;
    logic [mipsPkg::DataWidth-1:0]    jumpTarget;
    logic [mipsPkg::DataWidth-1:0]    signImm;
    logic [mipsPkg::DataWidth-1:0]    rsData;
    logic [mipsPkg::DataWidth-1:0]    rtData;
    logic [mipsPkg::DataWidth-1:0]    aluB;
    logic [mipsPkg::DataWidth-1:0]    aluResult;
    logic [mipsPkg::DataWidth-1:0]    wrData;
    logic [mipsPkg::RegAddrWidth-1:0] wrIdx;
    logic                             aluZero;
    logic                             takeBranch;

    // Next-address selection
    assign pcPlus4      = pc + 32'd4;
    assign signImm      = {{(mipsPkg::DataWidth-16){instr.i.imm[15]}}, instr.i.imm};
    assign branchTarget = pcPlus4 + {signImm[mipsPkg::DataWidth-3:0], 2'b00}; // Word offset
    assign jumpTarget   = {pcPlus4[31:28], instr.j.target, 2'b00};        // Region + target
    assign takeBranch   = (ctrl.beq && aluZero) || (ctrl.bne && !aluZero);

    always_comb begin
        if (ctrl.jump) begin
            pcNext = jumpTarget;
        end else if (takeBranch) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pcPlus4; // Also covers nop on undefined words
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0; // Word 0 runs first after reset
        end else begin
            pc <= pcNext;
        end
    end

    // Operand and destination muxes
    assign aluB  = ctrl.aluSrc ? signImm : rtData;
    assign wrIdx = ctrl.regDst ? instr.r.rd : instr.i.rt;

    registerFile u_regFile (
        .Clk    (Clk),
        .rst    (rst),
        .rs     (instr.i.rs),
        .rt     (instr.i.rt),
        .wrIdx  (wrIdx),
        .wrData (wrData),
        .wrEn   (ctrl.regWrite),
        .rsData (rsData),
        .rtData (rtData)
    );

    claAlu u_alu (
        .a      (rsData),
        .b      (aluB),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    // Memory side
    assign memRdAddr  = aluResult;
    assign wrData     = ctrl.memToReg ? memRdData : aluResult; // lw or ALU write-back
    assign store.en   = ctrl.memWrite && !rst; // No stores while held in reset
    assign store.addr = aluResult;
    assign store.data = rtData;

endmodule

/* src/mipsCore.sv */
`timescale 1ns/10ps

module mipsCore (
    input  logic                          Clk,
    input  logic                          rst,
    input  mipsPkg::imemLoad_t            imemLoad,
    output logic [mipsPkg::DataWidth-1:0] pc,
    output mipsPkg::storeBus_t            store
);

    mipsPkg::instrWord_t           instr;     // Fetched word
    mipsPkg::ctrlBundle_t          ctrl;      // Decoder to datapath
    logic [mipsPkg::DataWidth-1:0] memRdAddr;
    logic [mipsPkg::DataWidth-1:0] memRdData;

    instructionMemory u_imem (
        .Clk   (Clk),
        .load  (imemLoad),
        .pc    (pc),
        .instr (instr)
    );

    controlDecoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    datapath u_datapath (
        .Clk       (Clk),
        .rst       (rst),
        .instr     (instr),
        .ctrl      (ctrl),
        .memRdData (memRdData),
        .pc        (pc),
        .memRdAddr (memRdAddr),
        .store     (store)   // Shared with the top output
    );

    dataMemory u_dmem (
        .Clk    (Clk),
        .rdAddr (memRdAddr),
        .rdData (memRdData),
        .store  (store)
    );

endmodule

/* test/programTable.svh */
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

function automatic logic [31:0] rTypeWord(
    input logic [4:0] rs,
    input logic [4:0] rt,
    input logic [4:0] rd,
    input logic [5:0] funct
);
    return {mipsPkg::OpRType, rs, rt, rd, 5'd0, funct}; // shamt unused
endfunction

function automatic logic [31:0] immWord(
    input logic [5:0]  op,
    input logic [4:0]  rs,
    input logic [4:0]  rt,
    input logic [15:0] imm
);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] jumpWord(input logic [25:0] target);
    return {mipsPkg::OpJ, target}; // Target is a word index
endfunction

// One instruction word per entry, indexed by word address
localparam int ProgLen = 40;
localparam logic [31:0] ProgWords [ProgLen] = '{
    immWord(mipsPkg::OpAddi, 5'd0, 5'd1, 16'h0007),         // r1 = 7
    immWord(mipsPkg::OpAddi, 5'd0, 5'd2, 16'hFFFD),         // r2 = -3
    rTypeWord(5'd1, 5'd2, 5'd3, mipsPkg::FnAdd),            // r3 = 4
    immWord(mipsPkg::OpSw, 5'd0, 5'd3, 16'd0),
    rTypeWord(5'd1, 5'd2, 5'd4, mipsPkg::FnSub),            // r4 = 10
    immWord(mipsPkg::OpSw, 5'd0, 5'd4, 16'd4),
    immWord(mipsPkg::OpAddi, 5'd0, 5'd5, 16'h0F0F),
    immWord(mipsPkg::OpAddi, 5'd0, 5'd6, 16'h00FF),
    rTypeWord(5'd5, 5'd6, 5'd7, mipsPkg::FnAnd),            // r7 = 0x000F
    immWord(mipsPkg::OpSw, 5'd0, 5'd7, 16'd8),
    rTypeWord(5'd5, 5'd6, 5'd8, mipsPkg::FnOr),             // r8 = 0x0FFF
    immWord(mipsPkg::OpSw, 5'd0, 5'd8, 16'd12),
    rTypeWord(5'd2, 5'd1, 5'd9, mipsPkg::FnSlt),            // -3 < 7
    immWord(mipsPkg::OpSw, 5'd0, 5'd9, 16'd16),
    rTypeWord(5'd1, 5'd2, 5'd10, mipsPkg::FnSlt),           // 7 < -3 is false
    immWord(mipsPkg::OpSw, 5'd0, 5'd10, 16'd20),
    immWord(mipsPkg::OpAddi, 5'd0, 5'd11, 16'h7FFF),
    immWord(mipsPkg::OpAddi, 5'd0, 5'd12, 16'h0001),
    rTypeWord(5'd11, 5'd12, 5'd13, mipsPkg::FnAdd),         // Carry across groups
    immWord(mipsPkg::OpSw, 5'd0, 5'd13, 16'd24),
    immWord(mipsPkg::OpAddi, 5'd0, 5'd15, 16'hFFFF),        // r15 = -1
    rTypeWord(5'd2, 5'd15, 5'd14, mipsPkg::FnSlt),          // -3 < -1
    immWord(mipsPkg::OpSw, 5'd0, 5'd14, 16'd28),
    immWord(mipsPkg::OpSw, 5'd0, 5'd2, 16'd32),
    immWord(mipsPkg::OpLw, 5'd0, 5'd16, 16'd32),            // Read back
    immWord(mipsPkg::OpSw, 5'd0, 5'd16, 16'd36),
    immWord(mipsPkg::OpBeq, 5'd1, 5'd1, 16'd1),             // Taken
    immWord(mipsPkg::OpSw, 5'd0, 5'd1, 16'd40),             // Skipped
    immWord(mipsPkg::OpBeq, 5'd1, 5'd2, 16'd1),             // Not taken
    immWord(mipsPkg::OpSw, 5'd0, 5'd1, 16'd44),
    immWord(mipsPkg::OpBne, 5'd1, 5'd2, 16'd1),             // Taken
    immWord(mipsPkg::OpSw, 5'd0, 5'd1, 16'd48),             // Skipped
    immWord(mipsPkg::OpBne, 5'd1, 5'd1, 16'd1),             // Not taken
    immWord(mipsPkg::OpSw, 5'd0, 5'd1, 16'd52),
    jumpWord(26'd36),
    immWord(mipsPkg::OpSw, 5'd0, 5'd1, 16'd56),             // Skipped by j
    immWord(mipsPkg::OpSw, 5'd0, 5'd3, 16'd60),
    32'hFC22_1234,                                          // Opcode 0x3F is undefined
    immWord(mipsPkg::OpSw, 5'd0, 5'd4, 16'd64),
    jumpWord(26'd39)                                        // Park here
};

typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
} storeEvent_t;

// Byte address and stored word of each store in program order
localparam int NumStores = 14;
localparam storeEvent_t ExpStores [NumStores] = '{
    '{addr: 32'h00, data: 32'h0000_0004},
    '{addr: 32'h04, data: 32'h0000_000A},
    '{addr: 32'h08, data: 32'h0000_000F},
    '{addr: 32'h0C, data: 32'h0000_0FFF},
    '{addr: 32'h10, data: 32'h0000_0001},
    '{addr: 32'h14, data: 32'h0000_0000},
    '{addr: 32'h18, data: 32'h0000_8000},
    '{addr: 32'h1C, data: 32'h0000_0001},
    '{addr: 32'h20, data: 32'hFFFF_FFFD},
    '{addr: 32'h24, data: 32'hFFFF_FFFD},
    '{addr: 32'h2C, data: 32'h0000_0007},
    '{addr: 32'h34, data: 32'h0000_0007},
    '{addr: 32'h3C, data: 32'h0000_0004},
    '{addr: 32'h40, data: 32'h0000_000A}
};

`endif

/* test/mipsCoreTb.sv */
`timescale 1ns/10ps

module mipsCoreTb;

    localparam int ResetCycles  = 4;
    localparam int StoreTimeout = 200; // Cycles allowed per expected store
    localparam int QuietCycles  = 50;  // Watch window after the last store

    logic                          Clk;
    logic                          rst;
    mipsPkg::imemLoad_t            imemLoad;
    logic [mipsPkg::DataWidth-1:0] pc;
    mipsPkg::storeBus_t            store;

    int errors;
    int timeouts;
    int checks;
    bit stalled; // Set once a store never shows up

    `include "programTable.svh"

    mipsCore u_dut (
        .Clk      (Clk),
        .rst      (rst),
        .imemLoad (imemLoad),
        .pc       (pc),
        .store    (store)
    );

    always #2 Clk = ~Clk; // 4 ns period

    // Core parked at word 0 with the store bus idle
    task automatic verifyResetState();
        checks++;
        assert (pc == '0 && !store.en)
            else begin
                errors++;
                $display("[FAIL] %0t: pc=%h store.en=%b while reset held", $time, pc, store.en);
            end
    endtask

    task automatic awaitStore(input int idx);
        int waited;
        bit seen;
        waited = 0;
        seen   = 0;
        while (!seen && waited < StoreTimeout) begin
            @(negedge Clk); // Bus settled mid-cycle
            if (store.en) begin
                seen = 1;
            end else begin
                waited++;
            end
        end
        if (!seen) begin
            timeouts++;
            stalled = 1;
            $display("Timeout: store number %0d did not appear within %0d cycles",
                     idx, StoreTimeout);
        end else begin
            checks += 2;
            assert (store.addr == ExpStores[idx].addr)
                else begin
                    errors++;
                    $display("[FAIL] %0t: store %0d address %h, expected %h",
                             $time, idx, store.addr, ExpStores[idx].addr);
                end
            assert (store.data == ExpStores[idx].data)
                else begin
                    errors++;
                    $display("[FAIL] %0t: store %0d data %h, expected %h",
                             $time, idx, store.data, ExpStores[idx].data);
                end
        end
    endtask

    // Self-jump must not issue any more stores
    task automatic expectQuiet();
        for (int n = 0; n < QuietCycles; n++) begin
            @(negedge Clk);
            checks++;
            assert (!store.en)
                else begin
                    errors++;
                    $display("[FAIL] %0t: extra store to %h data %h after program end",
                             $time, store.addr, store.data);
                end
        end
    endtask

    initial begin
        Clk      = 1'b0;
        rst      = 1'b1;
        imemLoad = '0;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        stalled  = 0;

        repeat (ResetCycles) begin
            @(negedge Clk);
            verifyResetState();
        end

        // Program load of one word per cycle while reset holds the core
        for (int i = 0; i < ProgLen; i++) begin
            @(negedge Clk);
            verifyResetState();
            imemLoad.en   = 1'b1;
            imemLoad.idx  = i[$clog2(mipsPkg::ImemWords)-1:0];
            imemLoad.data = ProgWords[i];
        end

        @(negedge Clk);
        verifyResetState();
        imemLoad = '0;
        rst      = 1'b0; // Word 0 executes in this cycle

        #1;
        checks++;
        assert (pc == '0 && !store.en)
            else begin
                errors++;
                $display("[FAIL] %0t: first cycle after reset pc=%h store.en=%b",
                         $time, pc, store.en);
            end

        for (int idx = 0; idx < NumStores; idx++) begin
            if (!stalled) begin
                awaitStore(idx);
            end
        end
        if (!stalled) begin
            expectQuiet();
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* mipsCore.f */
+incdir+test
src/mipsPkg.sv
src/instructionMemory.sv
src/controlDecoder.sv
src/claAlu.sv
src/registerFile.sv
src/dataMemory.sv
src/datapath.sv
src/mipsCore.sv
test/mipsCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := mipsCoreTb
FLIST     := mipsCore.f

SRCS    := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard test/*.svh)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HEADERS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^SIMULATION PASSED$$'

clean:
	rm -rf obj_dir
